// File: flist.f
source/flstory_comm_pkg.sv
source/flstory_rst_stretch.sv
source/flstory_bus_arb.sv
source/flstory_mailbox.sv
source/flstory_comm.sv
dv/tb_clkgen.sv
dv/flstory_comm_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status of the simulation gives pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module flstory_comm_tb -f flist.f -o flstory_comm_sim &&
./obj_dir/flstory_comm_sim || exit 1

// File: dv/flstory_comm_tb.sv
// testbench for the main CPU / MCU communication core
// plays both processors, models the shared memory, checks with assertions

`timescale 1ns/1ps
`default_nettype none

module flstory_comm_tb
    import flstory_comm_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic              clk, rst, lhbl, rst_main;
    logic [ADDR_W-1:0] main_addr, mcu_addr, bus_addr;
    logic [DATA_W-1:0] main_dout, main_din, main_mb_din;
    logic [DATA_W-1:0] mcu_dout, mcu_din, mcu_mb_din, bus_dout, bus_din;
    logic              main_we, main_rd, main_mb_wr, main_mb_rd, main_wait;
    logic              mcu_busrq, mcu_we, mcu_rd, mcu_mb_wr, mcu_mb_rd, mcu_busak;
    logic              mcu_ibf, mcu_obf, bus_we, bus_rd, main_acc;
    logic [DATA_W-1:0] mem [256];

    tb_clkgen u_clkgen (.clk(clk), .rst(rst));

    flstory_comm #(.RST_LINES(4)) i_dut (.*);

    // shared memory filled from the address during reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 256; i++) begin
                mem[8'(i)] <= 8'(i) ^ 8'hc3;
            end
        end else if (bus_we) begin
            mem[bus_addr[7:0]] <= bus_dout;
        end
    end
    assign bus_din  = mem[bus_addr[7:0]];
    assign main_acc = main_we | main_rd;

    // short hblank period
    // rises never line up with the reset release
    initial begin
        lhbl = 1'b0;
        forever begin
            repeat (5) @(posedge clk);
            #1 lhbl = 1'b1;
            repeat (3) @(posedge clk);
            #1 lhbl = 1'b0;
        end
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // arbiter protocol
    a_grant: assert property (@(posedge clk) disable iff (rst)
        mcu_busrq && !mcu_busak && (rst_main || !main_acc) |=> mcu_busak)
        else stop_with_error("mcu_busak did not rise one cycle after a free bus cycle");
    a_busy: assert property (@(posedge clk) disable iff (rst)
        !mcu_busak && !rst_main && main_acc |=> !mcu_busak)
        else stop_with_error("mcu_busak rose while a main access was in progress");
    a_release: assert property (@(posedge clk) disable iff (rst)
        mcu_busak && !mcu_busrq |=> !mcu_busak)
        else stop_with_error("mcu_busak did not fall one cycle after mcu_busrq fell");
    a_stall: assert property (@(posedge clk) disable iff (rst)
        (mcu_busak && main_acc) == main_wait)
        else stop_with_error("main_wait does not match a main access during the grant");
    a_mcu_mux: assert property (@(posedge clk) disable iff (rst)
        mcu_busak |-> bus_addr == mcu_addr && bus_dout == mcu_dout
                      && bus_we == mcu_we && bus_rd == mcu_rd)
        else stop_with_error("shared bus does not follow the MCU while granted");
    a_rst_block: assert property (@(posedge clk) disable iff (rst)
        rst_main && !mcu_busak |-> !bus_we && !bus_rd)
        else stop_with_error("main strobe reached the bus while rst_main was high");
    // mailbox flags
    a_ibf_set: assert property (@(posedge clk) disable iff (rst)
        main_mb_wr |=> mcu_ibf && mcu_mb_din == $past(main_dout))
        else stop_with_error("main mailbox write did not set mcu_ibf with the byte");
    a_ibf_clr: assert property (@(posedge clk) disable iff (rst)
        mcu_mb_rd && !main_mb_wr |=> !mcu_ibf)
        else stop_with_error("MCU mailbox read did not clear mcu_ibf");
    a_obf_set: assert property (@(posedge clk) disable iff (rst)
        mcu_mb_wr |=> mcu_obf && main_mb_din == $past(mcu_dout))
        else stop_with_error("MCU mailbox write did not set mcu_obf with the byte");
    a_obf_clr: assert property (@(posedge clk) disable iff (rst)
        main_mb_rd && !mcu_mb_wr |=> !mcu_obf)
        else stop_with_error("main mailbox read did not clear mcu_obf");

    task automatic request_bus();
        int cycles;
        cycles = 0;
        mcu_busrq = 1'b1;
        while (!mcu_busak) begin
            if (cycles == TIMEOUT) begin
                stop_with_error("timed out waiting for mcu_busak");
            end
            cycles++;
            step();
        end
    endtask

    task automatic release_bus();
        int cycles;
        cycles = 0;
        mcu_busrq = 1'b0;
        mcu_we    = 1'b0;
        mcu_rd    = 1'b0;
        while (mcu_busak) begin
            if (cycles == TIMEOUT) begin
                stop_with_error("mcu_busak stayed high after the request dropped");
            end
            cycles++;
            step();
        end
    endtask

    task automatic mcu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        mcu_addr = addr;
        mcu_dout = data;
        mcu_we   = 1'b1;
        #1;
        expect_equal("mcu write address", 32'(addr), 32'(bus_addr));
        step();
        mcu_we = 1'b0;
    endtask

    task automatic mcu_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
        mcu_addr = addr;
        mcu_rd   = 1'b1;
        #1;
        expect_equal("mcu read data", 32'(exp), 32'(mcu_din));
        step();
        mcu_rd = 1'b0;
    endtask

    // strobe held through any stall
    // read data compared with data
    task automatic main_access(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic write);
        int cycles;
        cycles    = 0;
        main_addr = addr;
        main_dout = data;
        main_we   = write;
        main_rd   = !write;
        #1;
        while (main_wait) begin
            if (bus_we || bus_rd) begin
                stop_with_error("main strobe reached the bus during a stall");
            end
            if (cycles == TIMEOUT) begin
                stop_with_error("main access stalled past the timeout");
            end
            cycles++;
            @(posedge clk);
            #2;
        end
        expect_equal("main access address", 32'(addr), 32'(bus_addr));
        expect_equal("main access strobe", 32'd1, 32'(write ? bus_we : bus_rd));
        if (!write) begin
            expect_equal("main read data", 32'(data), 32'(main_din));
        end
        step();
        main_we = 1'b0;
        main_rd = 1'b0;
    endtask

    initial begin
        logic [ADDR_W-1:0] wr_addr [8];
        logic [DATA_W-1:0] wr_data [8];
        logic [DATA_W-1:0] b1;
        logic              prev_lhbl;
        int                rises;
        int                cycles;

        main_addr = '0;
        main_dout = '0;
        main_we   = 1'b0;
        main_rd   = 1'b0;
        main_mb_wr = 1'b0;
        main_mb_rd = 1'b0;
        mcu_busrq = 1'b0;
        mcu_addr  = '0;
        mcu_dout  = '0;
        mcu_we    = 1'b0;
        mcu_rd    = 1'b0;
        mcu_mb_wr = 1'b0;
        mcu_mb_rd = 1'b0;
        void'($urandom(32'hbe0e_b6be));

        @(posedge clk);
        #2;
        cycles = 0;
        while (rst) begin
            if (cycles == TIMEOUT) begin
                stop_with_error("board reset never released");
            end
            cycles++;
            @(posedge clk);
            #2;
        end
        expect_equal("busak after reset", 32'd0, 32'(mcu_busak));
        expect_equal("ibf after reset", 32'd0, 32'(mcu_ibf));
        expect_equal("obf after reset", 32'd0, 32'(mcu_obf));

        // reset stretch with main strobes toggling the whole time
        prev_lhbl = lhbl;
        rises     = 0;
        cycles    = 0;
        while (rises < 4) begin
            if (cycles == TIMEOUT) begin
                stop_with_error("too few lhbl rises seen after reset");
            end
            cycles++;
            step();
            main_addr = 16'(cycles);
            main_we   = cycles[0];
            main_rd   = !cycles[0];
            #1;
            if (lhbl && !prev_lhbl) begin
                rises++;
            end
            prev_lhbl = lhbl;
            expect_equal("rst_main held", 32'd1, 32'(rst_main));
        end
        cycles = 0;
        while (rst_main) begin
            if (cycles == 3) begin
                stop_with_error("rst_main still high 3 cycles after the fourth lhbl rise");
            end
            cycles++;
            step();
            main_we = 1'b0;
            main_rd = 1'b0;
            #1;
        end

        // request during a main read has to wait for it
        step();
        main_addr = 16'h0040;
        main_rd   = 1'b1;
        mcu_busrq = 1'b1;
        repeat (3) begin
            step();
            #1;
            expect_equal("busak during main access", 32'd0, 32'(mcu_busak));
        end
        step();
        main_rd = 1'b0;
        request_bus();

        for (int i = 0; i < 8; i++) begin
            wr_addr[i] = 16'(16 * i) | 16'($urandom % 16);
            wr_data[i] = 8'($urandom);
            mcu_write(wr_addr[i], wr_data[i]);
            repeat ($urandom % 3) step();
        end
        for (int i = 0; i < 8; i++) begin
            mcu_read(wr_addr[i], wr_data[i]);
        end
        mcu_read(16'h00a7, 8'ha7 ^ 8'hc3);

        // main write stalls until the MCU lets go
        b1 = 8'($urandom);
        fork
            main_access(16'h12c5, b1, 1'b1);
            begin
                repeat (3) step();
                release_bus();
            end
        join
        expect_equal("main write through", 32'(b1), 32'(mem[8'hc5]));
        main_access(16'h12c5, b1, 1'b0);

        // main to MCU mailbox
        b1 = 8'($urandom);
        main_dout  = b1;
        main_mb_wr = 1'b1;
        step();
        main_mb_wr = 1'b0;
        #1;
        expect_equal("ibf after write", 32'd1, 32'(mcu_ibf));
        expect_equal("mcu mailbox byte", 32'(b1), 32'(mcu_mb_din));
        step();
        mcu_mb_rd = 1'b1;
        step();
        mcu_mb_rd = 1'b0;
        #1;
        expect_equal("ibf after read", 32'd0, 32'(mcu_ibf));
        expect_equal("mcu mailbox byte kept", 32'(b1), 32'(mcu_mb_din));

        // overwrite and write against read on the MCU to main mailbox
        step();
        mcu_dout  = b1;
        mcu_mb_wr = 1'b1;
        step();
        mcu_dout = b1 ^ 8'hff;
        step();
        mcu_mb_wr = 1'b0;
        #1;
        expect_equal("obf after overwrite", 32'd1, 32'(mcu_obf));
        expect_equal("main mailbox overwrite", 32'(b1 ^ 8'hff), 32'(main_mb_din));
        step();
        mcu_dout   = b1 ^ 8'h5a;
        mcu_mb_wr  = 1'b1;
        main_mb_rd = 1'b1;
        step();
        mcu_mb_wr  = 1'b0;
        main_mb_rd = 1'b0;
        #1;
        expect_equal("obf write over read", 32'd1, 32'(mcu_obf));
        expect_equal("main mailbox new byte", 32'(b1 ^ 8'h5a), 32'(main_mb_din));
        repeat (2) begin
            // second pass reads an empty mailbox
            step();
            main_mb_rd = 1'b1;
            step();
            main_mb_rd = 1'b0;
            #1;
            expect_equal("obf after read", 32'd0, 32'(mcu_obf));
            expect_equal("main mailbox byte kept", 32'(b1 ^ 8'h5a), 32'(main_mb_din));
        end

        step();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
// clock and reset source for the testbench
// reset held for a fixed number of cycles, released just after an edge

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_NS    = 5,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: source/flstory_comm.sv
// main CPU / MCU communication core
// reset stretcher, shared bus arbiter and the two command mailboxes

`timescale 1ns/1ps
`default_nettype none

module flstory_comm
    import flstory_comm_pkg::*;
#(
    parameter int ADDR_W    = flstory_comm_pkg::ADDR_W,
    parameter int RST_LINES = RST_LINES_DEF
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              lhbl,
    output logic                   rst_main,
    // main CPU
    input  wire logic [ADDR_W-1:0] main_addr,
    input  wire logic [DATA_W-1:0] main_dout,
    input  wire logic              main_we,
    input  wire logic              main_rd,
    input  wire logic              main_mb_wr,
    input  wire logic              main_mb_rd,
    output logic      [DATA_W-1:0] main_din,
    output logic                   main_wait,
    output logic      [DATA_W-1:0] main_mb_din,
    // MCU
    input  wire logic              mcu_busrq,
    input  wire logic [ADDR_W-1:0] mcu_addr,
    input  wire logic [DATA_W-1:0] mcu_dout,
    input  wire logic              mcu_we,
    input  wire logic              mcu_rd,
    input  wire logic              mcu_mb_wr,
    input  wire logic              mcu_mb_rd,
    output logic                   mcu_busak,
    output logic      [DATA_W-1:0] mcu_din,
    output logic      [DATA_W-1:0] mcu_mb_din,
    // mailbox flags
    output logic                   mcu_ibf,
    output logic                   mcu_obf,
    // shared bus
    output logic      [ADDR_W-1:0] bus_addr,
    output logic      [DATA_W-1:0] bus_dout,
    output logic                   bus_we,
    output logic                   bus_rd,
    input  wire logic [DATA_W-1:0] bus_din
);

    // read data goes back to whichever side is master
    assign main_din = bus_din;
    assign mcu_din  = bus_din;

    // MCU gets the ports before the main CPU starts
    flstory_rst_stretch #(
        .RST_LINES (RST_LINES)
    ) u_rst (
        .clk      (clk),
        .rst      (rst),
        .lhbl     (lhbl),
        .rst_main (rst_main)
    );

    flstory_bus_arb #(
        .ADDR_W (ADDR_W)
    ) u_arb (
        .clk       (clk),
        .rst       (rst),
        .rst_main  (rst_main),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .main_we   (main_we),
        .main_rd   (main_rd),
        .main_wait (main_wait),
        .mcu_busrq (mcu_busrq),
        .mcu_addr  (mcu_addr),
        .mcu_dout  (mcu_dout),
        .mcu_we    (mcu_we),
        .mcu_rd    (mcu_rd),
        .mcu_busak (mcu_busak),
        .bus_addr  (bus_addr),
        .bus_dout  (bus_dout),
        .bus_we    (bus_we),
        .bus_rd    (bus_rd)
    );

    // commands from the main CPU
    flstory_mailbox u_to_mcu (
        .clk  (clk),
        .rst  (rst),
        .wr   (main_mb_wr),
        .din  (main_dout),
        .rd   (mcu_mb_rd),
        .dout (mcu_mb_din),
        .full (mcu_ibf)
    );

    // replies from the MCU
    flstory_mailbox u_to_main (
        .clk  (clk),
        .rst  (rst),
        .wr   (mcu_mb_wr),
        .din  (mcu_dout),
        .rd   (main_mb_rd),
        .dout (main_mb_din),
        .full (mcu_obf)
    );

endmodule

`default_nettype wire

// File: source/flstory_mailbox.sv
// one byte mailbox with full flag
// written by one processor, read by the other

`timescale 1ns/1ps
`default_nettype none

module flstory_mailbox
    import flstory_comm_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              wr,
    input  wire logic [DATA_W-1:0] din,
    input  wire logic              rd,
    output logic      [DATA_W-1:0] dout,
    output logic                   full
);

    logic [DATA_W-1:0] data;

    // latest byte wins, kept after the read
    always_ff @(posedge clk) begin
        if (wr) begin
            data <= din;
        end
    end

    // write beats a read in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (wr) begin
            full <= 1'b1;
        end else if (rd) begin
            full <= 1'b0;
        end
    end

    assign dout = data;

endmodule

`default_nettype wire

// File: source/flstory_bus_arb.sv
// shared bus arbiter between main CPU and MCU
// grants the bus to the MCU between main accesses and stalls the main CPU

`timescale 1ns/1ps
`default_nettype none

module flstory_bus_arb
    import flstory_comm_pkg::*;
#(
    parameter int ADDR_W = flstory_comm_pkg::ADDR_W
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              rst_main,
    // main CPU side
    input  wire logic [ADDR_W-1:0] main_addr,
    input  wire logic [DATA_W-1:0] main_dout,
    input  wire logic              main_we,
    input  wire logic              main_rd,
    output logic                   main_wait,
    // MCU side, bus master when granted
    input  wire logic              mcu_busrq,
    input  wire logic [ADDR_W-1:0] mcu_addr,
    input  wire logic [DATA_W-1:0] mcu_dout,
    input  wire logic              mcu_we,
    input  wire logic              mcu_rd,
    output logic                   mcu_busak,
    // shared bus
    output logic      [ADDR_W-1:0] bus_addr,
    output logic      [DATA_W-1:0] bus_dout,
    output logic                   bus_we,
    output logic                   bus_rd
);

    arb_state_t state;
    arb_state_t state_nx;
    logic       main_acc;
    logic       bus_free;

    assign main_acc = main_we | main_rd;
    // main CPU held in reset cannot be mid-access
    assign bus_free = rst_main | ~main_acc;

    always_comb begin
        state_nx = state;
        case (state)
            arb_main: begin
                if (mcu_busrq) begin
                    state_nx = bus_free ? arb_mcu : arb_drain;
                end
            end
            arb_drain: begin
                if (!mcu_busrq) begin
                    state_nx = arb_main;
                end else if (bus_free) begin
                    state_nx = arb_mcu;
                end
            end
            arb_mcu: begin
                // MCU done with the bus
                if (!mcu_busrq) begin
                    state_nx = arb_main;
                end
            end
            default: state_nx = arb_main;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_main;
        end else begin
            state <= state_nx;
        end
    end

    assign mcu_busak = (state == arb_mcu);

    // stall any main access while the MCU owns the bus
    assign main_wait = mcu_busak & main_acc;

    always_comb begin
        if (mcu_busak) begin
            bus_addr = mcu_addr;
            bus_dout = mcu_dout;
            bus_we   = mcu_we;
            bus_rd   = mcu_rd;
        end else begin
            bus_addr = main_addr;
            bus_dout = main_dout;
            // main strobes blocked while the main CPU is in reset
            bus_we   = main_we & ~rst_main;
            bus_rd   = main_rd & ~rst_main;
        end
    end

endmodule

`default_nettype wire

// File: source/flstory_rst_stretch.sv
// main CPU reset stretcher
// counts hblank starts after board reset so the MCU comes up first

`timescale 1ns/1ps
`default_nettype none

module flstory_rst_stretch
    import flstory_comm_pkg::*;
#(
    parameter int RST_LINES = RST_LINES_DEF
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic lhbl,
    output logic      rst_main
);

    localparam int CNT_W = (RST_LINES > 0) ? $clog2(RST_LINES + 1) : 1;
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(RST_LINES);

    logic             lhbl_l;
    logic             hb_rise;
    logic [CNT_W-1:0] cnt;
    logic             cnt_done;

    // lhbl delayed by one clock, free running
    always_ff @(posedge clk) begin
        lhbl_l <= lhbl;
    end

    assign hb_rise  = lhbl & ~lhbl_l;
    assign cnt_done = (cnt == CNT_END);

    // one count per hblank start, stops at the end value
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (hb_rise && !cnt_done) begin
            cnt <= cnt + 1'b1;
        end
    end

    // release one clock after the count is reached
    always_ff @(posedge clk) begin
        if (rst) begin
            rst_main <= 1'b1;
        end else begin
            rst_main <= !cnt_done;
        end
    end

endmodule

`default_nettype wire

// File: source/flstory_comm_pkg.sv
// shared widths and defaults for the main CPU / MCU communication core
// arbiter state encoding

`default_nettype none

package flstory_comm_pkg;

    // shared memory bus
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // main reset outlasts board reset by this many hblank starts
    localparam int RST_LINES_DEF = 16;

    // bus ownership
    typedef enum logic [1:0] {
        // main CPU drives the bus
        arb_main  = 2'd0,
        // request pending, main access still running
        arb_drain = 2'd1,
        // MCU is bus master
        arb_mcu   = 2'd2
    } arb_state_t;

endpackage

`default_nettype wire
